// ==== dv/segre_dcache_assertions.sv ====
`default_nettype none

module segre_dcache_assertions (
    input logic                             clk_i,
    input logic                             rsn_i,
    input logic                             mem_rd_i,
    input logic                             mem_wr_i,
    input logic                             rcvd_i,
    input logic                             hit_i,
    input logic                             busy_i,
    input logic [segre_pkg::WORD_SIZE-1:0]  wb_addr_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // failed assertions so far
    int fail_count = 0;

    ////////////////////////////////////////
    // memory side
    ////////////////////////////////////////

    a_one_request: assert property (@(posedge clk_i) disable iff (!rsn_i)
        !(mem_rd_i && mem_wr_i))
        else begin
            $error("rd_o and wr_o are high in the same cycle");
            fail_count++;
        end

    // level requests stay up until the memory takes them
    a_rd_held: assert property (@(posedge clk_i) disable iff (!rsn_i)
        (mem_rd_i && !rcvd_i) |=> mem_rd_i)
        else begin
            $error("rd_o dropped before rcvd_mem_request_i");
            fail_count++;
        end

    a_wr_held: assert property (@(posedge clk_i) disable iff (!rsn_i)
        (mem_wr_i && !rcvd_i) |=> mem_wr_i)
        else begin
            $error("wr_o dropped before rcvd_mem_request_i");
            fail_count++;
        end

    a_wb_addr_stable: assert property (@(posedge clk_i) disable iff (!rsn_i)
        (mem_wr_i && !rcvd_i) |=> $stable(wb_addr_i))
        else begin
            $error("writeback_addr_o changed while wr_o was pending");
            fail_count++;
        end

    ////////////////////////////////////////
    // core side
    ////////////////////////////////////////

    a_no_hit_busy: assert property (@(posedge clk_i) disable iff (!rsn_i)
        !(hit_i && busy_i))
        else begin
            $error("is_hit_o raised while is_busy_o is high");
            fail_count++;
        end

endmodule : segre_dcache_assertions

bind segre_dcache segre_dcache_assertions u_assertions (
    .clk_i     (clk_i),
    .rsn_i     (rsn_i),
    .mem_rd_i  (rd_o),
    .mem_wr_i  (wr_o),
    .rcvd_i    (rcvd_mem_request_i),
    .hit_i     (is_hit_o),
    .busy_i    (is_busy_o),
    .wb_addr_i (writeback_addr_o)
);

`default_nettype wire

// ==== dv/tb_segre_dcache.sv ====
`default_nettype none

module tb_segre_dcache;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_BYTES   = 256;
    localparam int HIT_TIMEOUT = 200;

    typedef struct {
        string                       name;
        bit                          is_store;
        segre_pkg::memop_data_type_e dtype;
        logic [31:0]                 addr;
        logic [31:0]                 data;
        int                          exp_fill;
        int                          exp_wb;
    } row_t;

    logic                        clk_i;
    logic                        rsn_i;
    logic                        rd_i;
    logic                        wr_i;
    segre_pkg::memop_data_type_e data_type_i;
    logic [31:0]                 addr_i;
    logic [31:0]                 data_i;
    logic                        rcvd_mem_request_i;
    segre_pkg::cache_line_t      from_mem_line_i;
    logic                        is_hit_o;
    logic                        is_busy_o;
    logic                        rd_o;
    logic                        wr_o;
    logic [31:0]                 data_o;
    logic [31:0]                 mem_addr_o;
    logic [31:0]                 writeback_addr_o;
    segre_pkg::cache_line_t      to_mem_line_o;

    // backing memory seen by the bus, and the reference view of the core
    logic [7:0]  backing_mem [MEM_BYTES];
    logic [7:0]  ref_mem [MEM_BYTES];
    logic [31:0] resident [segre_pkg::NUM_LINES];
    row_t        rows [$];
    logic [31:0] rng_state;
    logic [31:0] cur_addr;
    int          fill_count;
    int          wb_count;

    segre_dcache u_segre_dcache (
        .clk_i              (clk_i),
        .rsn_i              (rsn_i),
        .rd_i               (rd_i),
        .wr_i               (wr_i),
        .data_type_i        (data_type_i),
        .addr_i             (addr_i),
        .data_i             (data_i),
        .rcvd_mem_request_i (rcvd_mem_request_i),
        .from_mem_line_i    (from_mem_line_i),
        .is_hit_o           (is_hit_o),
        .is_busy_o          (is_busy_o),
        .rd_o               (rd_o),
        .wr_o               (wr_o),
        .data_o             (data_o),
        .mem_addr_o         (mem_addr_o),
        .writeback_addr_o   (writeback_addr_o),
        .to_mem_line_o      (to_mem_line_o)
    );

    always #4 clk_i = ~clk_i;

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("error: %s expected %h actual %h", name, exp, act);
        $display("test failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic fail_plain(input string what);
        $display("error: %s", what);
        $display("test failed");
        $fatal(1, "protocol failure");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int access_bytes(input segre_pkg::memop_data_type_e dtype);
        case (dtype)
            segre_pkg::BYTE: return 1;
            segre_pkg::HALF: return 2;
            default: return 4;
        endcase
    endfunction

    // zero extended load from the reference bytes, naturally aligned
    function automatic logic [31:0] model_load(input segre_pkg::memop_data_type_e dtype,
                                               input logic [31:0] addr);
        logic [31:0] val;
        int          n;
        int          base;
        n    = access_bytes(dtype);
        base = int'(addr[7:0]) & ~(n - 1);
        val  = '0;
        for (int k = 0; k < n; k++) begin
            val[8*k +: 8] = ref_mem[base + k];
        end
        return val;
    endfunction

    task automatic model_store(input segre_pkg::memop_data_type_e dtype,
                               input logic [31:0] addr, input logic [31:0] data);
        int n;
        int base;
        n    = access_bytes(dtype);
        base = int'(addr[7:0]) & ~(n - 1);
        for (int k = 0; k < n; k++) begin
            ref_mem[base + k] = data[8*k +: 8];
        end
    endtask

    task automatic check_idle(input string when);
        assert (!is_hit_o && !is_busy_o && !rd_o && !wr_o)
            else fail_plain({"cache outputs active ", when});
    endtask

    task automatic add_row(input string name, input bit is_store,
                           input segre_pkg::memop_data_type_e dtype, input logic [31:0] addr,
                           input logic [31:0] data, input int exp_fill, input int exp_wb);
        row_t r;
        r.name     = name;
        r.is_store = is_store;
        r.dtype    = dtype;
        r.addr     = addr;
        r.data     = data;
        r.exp_fill = exp_fill;
        r.exp_wb   = exp_wb;
        rows.push_back(r);
    endtask

    // protocol checks bound into the DUT
    always @(u_segre_dcache.u_assertions.fail_count) begin
        if (u_segre_dcache.u_assertions.fail_count != 0) begin
            fail_plain("a bound protocol assertion failed");
        end
    end

    ////////////////////////////////////////
    // memory responder
    ////////////////////////////////////////

    always begin : mem_responder
        int delay;
        int base;
        @(negedge clk_i);
        if (rsn_i && (rd_o || wr_o)) begin
            assert (is_busy_o)
                else fail_plain("is_busy_o low while a memory request is pending");
            rng_state = xorshift32(rng_state);
            delay     = int'(rng_state % 4);
            repeat (delay) @(negedge clk_i);
            if (wr_o) begin
                assert (writeback_addr_o === resident[cur_addr[5:4]])
                    else fail_value("writeback address", resident[cur_addr[5:4]],
                                    writeback_addr_o);
                base = int'(writeback_addr_o[7:0]);
                for (int b = 0; b < segre_pkg::LINE_BYTES; b++) begin
                    assert (to_mem_line_o[b] === ref_mem[base + b])
                        else fail_value("writeback line", ref_mem[base + b], to_mem_line_o[b]);
                    backing_mem[base + b] = to_mem_line_o[b];
                end
                wb_count++;
            end
            else begin
                assert (mem_addr_o === {cur_addr[31:4], 4'h0})
                    else fail_value("fill address", {cur_addr[31:4], 4'h0}, mem_addr_o);
                base = int'(mem_addr_o[7:0]);
                for (int b = 0; b < segre_pkg::LINE_BYTES; b++) begin
                    from_mem_line_i[b] = backing_mem[base + b];
                end
                resident[mem_addr_o[5:4]] = mem_addr_o;
                fill_count++;
            end
            rcvd_mem_request_i = 1'b1;
            @(negedge clk_i);
            rcvd_mem_request_i = 1'b0;
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic build_table();
        add_row("cold_load_word",     0, segre_pkg::WORD, 32'h10, 32'h0,        1, 0);
        add_row("load_byte_same",     0, segre_pkg::BYTE, 32'h13, 32'h0,        0, 0);
        add_row("load_half_same",     0, segre_pkg::HALF, 32'h16, 32'h0,        0, 0);
        add_row("load_word_same",     0, segre_pkg::WORD, 32'h1c, 32'h0,        0, 0);
        add_row("store_word",         1, segre_pkg::WORD, 32'h14, 32'hdeadbeef, 0, 0);
        add_row("load_after_store",   0, segre_pkg::WORD, 32'h14, 32'h0,        0, 0);
        add_row("store_byte",         1, segre_pkg::BYTE, 32'h15, 32'ha5,       0, 0);
        add_row("store_half",         1, segre_pkg::HALF, 32'h1a, 32'h1234,     0, 0);
        add_row("load_half_overlap",  0, segre_pkg::HALF, 32'h14, 32'h0,        0, 0);
        add_row("load_byte_overlap",  0, segre_pkg::BYTE, 32'h1b, 32'h0,        0, 0);
        add_row("load_word_merged",   0, segre_pkg::WORD, 32'h18, 32'h0,        0, 0);
        add_row("evict_dirty_idx1",   0, segre_pkg::WORD, 32'h50, 32'h0,        1, 1);
        add_row("reload_clean_idx1",  0, segre_pkg::WORD, 32'h14, 32'h0,        1, 0);
        add_row("cold_store_miss",    1, segre_pkg::BYTE, 32'h23, 32'h77,       1, 0);
        add_row("load_after_miss_st", 0, segre_pkg::WORD, 32'h20, 32'h0,        0, 0);
        add_row("store_half_idx3",    1, segre_pkg::HALF, 32'h30, 32'hbeef,     1, 0);
        add_row("store_word_idx3",    1, segre_pkg::WORD, 32'h3c, 32'h01020304, 0, 0);
        add_row("evict_dirty_idx3",   0, segre_pkg::BYTE, 32'hb1, 32'h0,        1, 1);
        add_row("evict_dirty_idx2",   0, segre_pkg::HALF, 32'he2, 32'h0,        1, 1);
        add_row("reload_idx3",        0, segre_pkg::WORD, 32'h3c, 32'h0,        1, 0);
        add_row("reload_idx2",        0, segre_pkg::BYTE, 32'h23, 32'h0,        1, 0);
        add_row("load_half_idx1_hit", 0, segre_pkg::HALF, 32'h18, 32'h0,        0, 0);
    endtask

    // entered and left on a falling edge
    task automatic apply_row(input row_t r);
        int          cycles;
        int          fill0;
        int          wb0;
        bit          hit;
        logic [31:0] got;
        fill0       = fill_count;
        wb0         = wb_count;
        cur_addr    = r.addr;
        rd_i        = !r.is_store;
        wr_i        = r.is_store;
        addr_i      = r.addr;
        data_i      = r.data;
        data_type_i = r.dtype;
        hit         = 1'b0;
        got         = '0;
        cycles      = 0;
        while (!hit && cycles < HIT_TIMEOUT) begin
            #2;
            if (is_hit_o) begin
                hit = 1'b1;
                got = data_o;
            end
            @(negedge clk_i);
            cycles++;
        end
        rd_i = 1'b0;
        wr_i = 1'b0;
        assert (hit) else fail_plain({r.name, " never got is_hit_o before the timeout"});
        if (r.is_store) begin
            model_store(r.dtype, r.addr, r.data);
        end
        else begin
            assert (got === model_load(r.dtype, r.addr))
                else fail_value(r.name, model_load(r.dtype, r.addr), got);
        end
        assert (fill_count - fill0 == r.exp_fill)
            else fail_value({r.name, " fills"}, r.exp_fill, fill_count - fill0);
        assert (wb_count - wb0 == r.exp_wb)
            else fail_value({r.name, " writebacks"}, r.exp_wb, wb_count - wb0);
    endtask

    initial begin
        clk_i              = 1'b0;
        rsn_i              = 1'b0;
        rd_i               = 1'b0;
        wr_i               = 1'b0;
        data_type_i        = segre_pkg::WORD;
        addr_i             = '0;
        data_i             = '0;
        rcvd_mem_request_i = 1'b0;
        from_mem_line_i    = '0;
        rng_state          = 32'd40500;
        cur_addr           = '0;
        fill_count         = 0;
        wb_count           = 0;
        // 37 is odd, so every address bit changes the pattern
        for (int a = 0; a < MEM_BYTES; a++) begin
            backing_mem[a] = 8'(a * 37 + 11);
            ref_mem[a]     = 8'(a * 37 + 11);
        end
        build_table();

        repeat (8) begin
            @(negedge clk_i);
            check_idle("during reset");
        end
        rsn_i = 1'b1;
        #2;
        check_idle("right after reset");
        @(negedge clk_i);

        foreach (rows[i]) begin
            apply_row(rows[i]);
        end

        if (u_segre_dcache.u_assertions.fail_count == 0) begin
            $display("test passed");
            $finish;
        end
        else begin
            fail_plain("bound protocol assertions failed during the run");
        end
    end

endmodule : tb_segre_dcache

`default_nettype wire

// ==== project.f ====
verilog/segre_pkg.sv
verilog/segre_sb_drain_if.sv
verilog/segre_cache_tags.sv
verilog/segre_cache_data.sv
verilog/segre_store_buffer.sv
verilog/segre_cache_ctrl.sv
verilog/segre_dcache.sv
dv/segre_dcache_assertions.sv
dv/tb_segre_dcache.sv

// ==== verilog/segre_cache_ctrl.sv ====
`default_nettype none

module segre_cache_ctrl (
    input  logic                              clk_i,
    input  logic                              rsn_i,
    input  logic                              rd_i,
    input  logic                              wr_i,
    input  segre_pkg::cache_addr_u            addr_i,
    input  logic                              tag_match_i,
    input  logic [segre_pkg::TAG_BITS-1:0]    stored_tag_i,
    input  logic                              sb_load_match_i,
    input  logic                              sb_full_i,
    input  logic                              sb_empty_i,
    segre_sb_drain_if.ctrl                    drain,
    input  logic                              rcvd_mem_request_i,
    output logic                              fill_en_o,
    output logic                              sb_push_o,
    output logic                              is_hit_o,
    output logic                              is_busy_o,
    output logic                              rd_o,
    output logic                              wr_o,
    output logic [segre_pkg::WORD_SIZE-1:0]   mem_addr_o,
    output logic [segre_pkg::WORD_SIZE-1:0]   writeback_addr_o
);

    segre_pkg::ctrl_state_e state;
    segre_pkg::ctrl_state_e next_state;

    logic [segre_pkg::NUM_LINES-1:0]   valid_bits;
    logic [segre_pkg::NUM_LINES-1:0]   dirty_bits;
    logic [segre_pkg::INDEX_BITS-1:0]  idx;
    logic                              in_lookup;
    logic                              line_hit;
    logic                              load_hit;
    logic                              store_hit;
    logic                              miss_start;

    assign idx       = addr_i.fields.index;
    assign in_lookup = (state == segre_pkg::LOOKUP);
    assign line_hit  = valid_bits[idx] && tag_match_i;

    ////////////////////////////////////////
    // hit / miss decision
    ////////////////////////////////////////

    // load waits while a store to the same word is still buffered
    assign load_hit  = rd_i && in_lookup && line_hit && !sb_load_match_i;
    assign store_hit = wr_i && in_lookup && line_hit && !sb_full_i;

    assign is_hit_o  = load_hit || store_hit;
    assign sb_push_o = store_hit;

    // an empty buffer guarantees no pending store targets the victim
    assign miss_start = (rd_i || wr_i) && in_lookup && !line_hit && sb_empty_i;

    ////////////////////////////////////////
    // miss FSM
    ////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            segre_pkg::LOOKUP: begin
                if (miss_start) begin
                    if (valid_bits[idx] && dirty_bits[idx]) begin
                        next_state = segre_pkg::WRITEBACK;
                    end
                    else begin
                        next_state = segre_pkg::FILL;
                    end
                end
            end
            segre_pkg::WRITEBACK: begin
                if (rcvd_mem_request_i) begin
                    next_state = segre_pkg::FILL;
                end
            end
            segre_pkg::FILL: begin
                if (rcvd_mem_request_i) begin
                    next_state = segre_pkg::LOOKUP;
                end
            end
            default: next_state = segre_pkg::LOOKUP;
        endcase
    end

    always_ff @(posedge clk_i, negedge rsn_i) begin
        if (!rsn_i) begin
            state <= segre_pkg::LOOKUP;
        end
        else begin
            state <= next_state;
        end
    end

    // line data arrives in the rcvd cycle of the fill
    assign fill_en_o = (state == segre_pkg::FILL) && rcvd_mem_request_i;

    always_ff @(posedge clk_i, negedge rsn_i) begin
        if (!rsn_i) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end
        else begin
            if (drain.valid) begin
                dirty_bits[drain.addr.fields.index] <= 1'b1;
            end
            if (fill_en_o) begin
                valid_bits[idx] <= 1'b1;
                dirty_bits[idx] <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // memory side
    ////////////////////////////////////////

    // level requests, held by the state until rcvd
    assign rd_o      = (state == segre_pkg::FILL);
    assign wr_o      = (state == segre_pkg::WRITEBACK);
    assign is_busy_o = !in_lookup;

    assign mem_addr_o = {addr_i.fields.tag, idx, {segre_pkg::OFFSET_BITS{1'b0}}};

    // tag array only changes on a fill, so this stays stable in WRITEBACK
    assign writeback_addr_o = {stored_tag_i, idx, {segre_pkg::OFFSET_BITS{1'b0}}};

endmodule : segre_cache_ctrl

`default_nettype wire

// ==== verilog/segre_cache_data.sv ====
`default_nettype none

module segre_cache_data (
    input  logic                              clk_i,
    input  logic                              rsn_i,
    input  segre_pkg::cache_addr_u            lookup_addr_i,
    input  segre_pkg::memop_data_type_e       data_type_i,
    input  logic                              fill_en_i,
    input  segre_pkg::cache_line_t            from_mem_line_i,
    segre_sb_drain_if.array                   drain,
    output logic [segre_pkg::WORD_SIZE-1:0]   data_o,
    output segre_pkg::cache_line_t            victim_line_o
);

    segre_pkg::cache_line_t                lines [segre_pkg::NUM_LINES];
    segre_pkg::cache_line_t                cur_line;
    segre_pkg::cache_line_t                drain_line;
    logic [segre_pkg::LINE_BYTES-1:0]      drain_be;
    logic [segre_pkg::OFFSET_BITS-1:0]     off;
    logic [segre_pkg::OFFSET_BITS-1:0]     drain_off;

    assign cur_line      = lines[lookup_addr_i.fields.index];
    assign off           = lookup_addr_i.fields.offset;
    assign drain_off     = drain.addr.fields.offset;
    assign victim_line_o = cur_line;

    ////////////////////////////////////////
    // read path, zero extended
    ////////////////////////////////////////

    always_comb begin
        data_o = '0;
        case (data_type_i)
            segre_pkg::BYTE: data_o[7:0] = cur_line[off];
            segre_pkg::HALF: data_o[15:0] = {cur_line[{off[3:1], 1'b1}],
                                             cur_line[{off[3:1], 1'b0}]};
            default: data_o = {cur_line[{off[3:2], 2'b11}], cur_line[{off[3:2], 2'b10}],
                               cur_line[{off[3:2], 2'b01}], cur_line[{off[3:2], 2'b00}]};
        endcase
    end

    ////////////////////////////////////////
    // drain merge
    ////////////////////////////////////////

    // store data replicated across the line, enables pick the lanes
    always_comb begin
        for (int b = 0; b < segre_pkg::LINE_BYTES; b++) begin
            case (drain.data_type)
                segre_pkg::BYTE: begin
                    drain_line[b] = drain.data[7:0];
                    drain_be[b]   = (b == int'(drain_off));
                end
                segre_pkg::HALF: begin
                    drain_line[b] = drain.data[(b % 2)*8 +: 8];
                    drain_be[b]   = ((b >> 1) == int'(drain_off >> 1));
                end
                default: begin
                    drain_line[b] = drain.data[(b % 4)*8 +: 8];
                    drain_be[b]   = ((b >> 2) == int'(drain_off >> 2));
                end
            endcase
        end
    end

    // fill and drain never overlap, a fill waits for an empty buffer
    always_ff @(posedge clk_i, negedge rsn_i) begin
        if (!rsn_i) begin
            for (int i = 0; i < segre_pkg::NUM_LINES; i++) begin
                lines[i] <= '0;
            end
        end
        else begin
            if (fill_en_i) begin
                lines[lookup_addr_i.fields.index] <= from_mem_line_i;
            end
            if (drain.valid) begin
                for (int b = 0; b < segre_pkg::LINE_BYTES; b++) begin
                    if (drain_be[b]) begin
                        lines[drain.addr.fields.index][b] <= drain_line[b];
                    end
                end
            end
        end
    end

endmodule : segre_cache_data

`default_nettype wire

// ==== verilog/segre_cache_tags.sv ====
`default_nettype none

module segre_cache_tags (
    input  logic                             clk_i,
    input  logic                             rsn_i,
    input  segre_pkg::cache_addr_u           lookup_addr_i,
    input  logic                             fill_en_i,
    output logic                             tag_match_o,
    output logic [segre_pkg::TAG_BITS-1:0]   stored_tag_o
);

    logic [segre_pkg::TAG_BITS-1:0] tag_mem [segre_pkg::NUM_LINES];

    // the tag is written together with the fill of the line
    always_ff @(posedge clk_i, negedge rsn_i) begin
        if (!rsn_i) begin
            for (int i = 0; i < segre_pkg::NUM_LINES; i++) begin
                tag_mem[i] <= '0;
            end
        end
        else if (fill_en_i) begin
            tag_mem[lookup_addr_i.fields.index] <= lookup_addr_i.fields.tag;
        end
    end

    // stored tag also feeds the writeback address
    assign stored_tag_o = tag_mem[lookup_addr_i.fields.index];
    assign tag_match_o  = (stored_tag_o == lookup_addr_i.fields.tag);

endmodule : segre_cache_tags

`default_nettype wire

// ==== verilog/segre_dcache.sv ====
`default_nettype none

module segre_dcache (
    input  logic                              clk_i,
    input  logic                              rsn_i,
    input  logic                              rd_i,
    input  logic                              wr_i,
    input  segre_pkg::memop_data_type_e       data_type_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]   addr_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]   data_i,
    input  logic                              rcvd_mem_request_i,
    input  segre_pkg::cache_line_t            from_mem_line_i,
    output logic                              is_hit_o,
    output logic                              is_busy_o,
    output logic                              rd_o,
    output logic                              wr_o,
    output logic [segre_pkg::WORD_SIZE-1:0]   data_o,
    output logic [segre_pkg::WORD_SIZE-1:0]   mem_addr_o,
    output logic [segre_pkg::WORD_SIZE-1:0]   writeback_addr_o,
    output segre_pkg::cache_line_t            to_mem_line_o
);

    logic                              fill_en;
    logic                              sb_push;
    logic                              tag_match;
    logic [segre_pkg::TAG_BITS-1:0]    stored_tag;
    logic                              sb_load_match;
    logic                              sb_full;
    logic                              sb_empty;

    segre_sb_drain_if drain_if ();

    ////////////////////////////////////////
    // blocks
    ////////////////////////////////////////

    segre_cache_ctrl u_ctrl (
        .clk_i              (clk_i),
        .rsn_i              (rsn_i),
        .rd_i               (rd_i),
        .wr_i               (wr_i),
        .addr_i             (addr_i),
        .tag_match_i        (tag_match),
        .stored_tag_i       (stored_tag),
        .sb_load_match_i    (sb_load_match),
        .sb_full_i          (sb_full),
        .sb_empty_i         (sb_empty),
        .drain              (drain_if.ctrl),
        .rcvd_mem_request_i (rcvd_mem_request_i),
        .fill_en_o          (fill_en),
        .sb_push_o          (sb_push),
        .is_hit_o           (is_hit_o),
        .is_busy_o          (is_busy_o),
        .rd_o               (rd_o),
        .wr_o               (wr_o),
        .mem_addr_o         (mem_addr_o),
        .writeback_addr_o   (writeback_addr_o)
    );

    segre_cache_tags u_tags (
        .clk_i         (clk_i),
        .rsn_i         (rsn_i),
        .lookup_addr_i (addr_i),
        .fill_en_i     (fill_en),
        .tag_match_o   (tag_match),
        .stored_tag_o  (stored_tag)
    );

    segre_cache_data u_data (
        .clk_i           (clk_i),
        .rsn_i           (rsn_i),
        .lookup_addr_i   (addr_i),
        .data_type_i     (data_type_i),
        .fill_en_i       (fill_en),
        .from_mem_line_i (from_mem_line_i),
        .drain           (drain_if.array),
        .data_o          (data_o),
        .victim_line_o   (to_mem_line_o)
    );

    segre_store_buffer u_sb (
        .clk_i        (clk_i),
        .rsn_i        (rsn_i),
        .push_i       (sb_push),
        .addr_i       (addr_i),
        .data_i       (data_i),
        .data_type_i  (data_type_i),
        .load_match_o (sb_load_match),
        .full_o       (sb_full),
        .empty_o      (sb_empty),
        .drain        (drain_if.source)
    );

endmodule : segre_dcache

`default_nettype wire

// ==== verilog/segre_pkg.sv ====
`default_nettype none

package segre_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////

    // address and data width
    localparam int WORD_SIZE   = 32;

    // geometry: 4 lines of 16 bytes, direct mapped
    localparam int LINE_BYTES  = 16;
    localparam int NUM_LINES   = 4;
    localparam int OFFSET_BITS = 4;
    localparam int INDEX_BITS  = 2;
    localparam int TAG_BITS    = WORD_SIZE - INDEX_BITS - OFFSET_BITS;

    // store buffer depth
    localparam int SB_ENTRIES  = 2;

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } memop_data_type_e;

    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [INDEX_BITS-1:0]  index;
        logic [OFFSET_BITS-1:0] offset;
    } cache_addr_fields_t;

    // same address word, seen raw or split into tag/index/offset
    typedef union packed {
        logic [WORD_SIZE-1:0] raw;
        cache_addr_fields_t   fields;
    } cache_addr_u;

    typedef logic [LINE_BYTES-1:0][7:0] cache_line_t;

    typedef enum logic [1:0] {
        LOOKUP,
        WRITEBACK,
        FILL
    } ctrl_state_e;

endpackage : segre_pkg

`default_nettype wire

// ==== verilog/segre_sb_drain_if.sv ====
`default_nettype none

// one store leaving the store buffer per cycle
interface segre_sb_drain_if;

    logic                              valid;
    segre_pkg::cache_addr_u            addr;
    logic [segre_pkg::WORD_SIZE-1:0]   data;
    segre_pkg::memop_data_type_e       data_type;

    modport source (output valid, addr, data, data_type);

    // data array merges the store bytes into the line
    modport array (input valid, addr, data, data_type);

    // controller only needs the index to mark the line dirty
    modport ctrl (input valid, addr);

endinterface : segre_sb_drain_if

`default_nettype wire

// ==== verilog/segre_store_buffer.sv ====
`default_nettype none

module segre_store_buffer (
    input  logic                              clk_i,
    input  logic                              rsn_i,
    input  logic                              push_i,
    input  segre_pkg::cache_addr_u            addr_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]   data_i,
    input  segre_pkg::memop_data_type_e       data_type_i,
    output logic                              load_match_o,
    output logic                              full_o,
    output logic                              empty_o,
    segre_sb_drain_if.source                  drain
);

    segre_pkg::cache_addr_u            sb_addr  [segre_pkg::SB_ENTRIES];
    logic [segre_pkg::WORD_SIZE-1:0]   sb_data  [segre_pkg::SB_ENTRIES];
    segre_pkg::memop_data_type_e       sb_dtype [segre_pkg::SB_ENTRIES];
    logic [segre_pkg::SB_ENTRIES-1:0]  sb_valid;
    logic [segre_pkg::SB_ENTRIES-1:0]  match_vec;

    logic [$clog2(segre_pkg::SB_ENTRIES)-1:0] wr_ptr;
    logic [$clog2(segre_pkg::SB_ENTRIES)-1:0] rd_ptr;

    assign full_o  = &sb_valid;
    assign empty_o = ~|sb_valid;

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////

    // oldest entry leaves every cycle the buffer holds something;
    // push never hits a full slot and pop never an empty one
    always_ff @(posedge clk_i, negedge rsn_i) begin
        if (!rsn_i) begin
            sb_valid <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
        end
        else begin
            if (!empty_o) begin
                sb_valid[rd_ptr] <= 1'b0;
                rd_ptr           <= rd_ptr + 1'b1;
            end
            if (push_i) begin
                sb_valid[wr_ptr] <= 1'b1;
                wr_ptr           <= wr_ptr + 1'b1;
            end
        end
    end

    // payload
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            sb_addr[wr_ptr]  <= addr_i;
            sb_data[wr_ptr]  <= data_i;
            sb_dtype[wr_ptr] <= data_type_i;
        end
    end

    assign drain.valid     = !empty_o;
    assign drain.addr      = sb_addr[rd_ptr];
    assign drain.data      = sb_data[rd_ptr];
    assign drain.data_type = sb_dtype[rd_ptr];

    // word granularity, any store in the same word blocks the load
    always_comb begin
        for (int i = 0; i < segre_pkg::SB_ENTRIES; i++) begin
            match_vec[i] = sb_valid[i] &&
                (sb_addr[i].raw[segre_pkg::WORD_SIZE-1:2] ==
                 addr_i.raw[segre_pkg::WORD_SIZE-1:2]);
        end
    end

    assign load_match_o = |match_vec;

endmodule : segre_store_buffer

`default_nettype wire
